//--- sources.f
+incdir+src
src/pdp8_isa_pkg.sv
src/pdp8_cycle_pkg.sv
src/front_panel_apb.sv
src/interrupt_ctrl.sv
src/eae_step_counter.sv
src/major_state_seq.sv
src/pdp8_cpu_ctl.sv
sim/ctl_checker.sv
sim/tb_pdp8_cpu_ctl.sv

//--- sim/tb_pdp8_cpu_ctl.sv
`default_nettype none
`include "pdp8_config.svh"

module tb_pdp8_cpu_ctl
    import pdp8_isa_pkg::*;
    import pdp8_cycle_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int         MAX_ROWS = 16;
    localparam logic [4:0] NONE     = 5'h1f;    // Unused push slot

    logic clk;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic int_req;
    logic pready;
    logic int_in_prog;
    logic done;
    logic [3:0] paddr;
    logic [`PDP8_WORD_BITS-1:0] pwdata;
    logic [`PDP8_WORD_BITS-1:0] prdata;
    major_state_t state;

    logic [11:0] row_ctrl [MAX_ROWS];
    logic [11:0] row_instr [MAX_ROWS];
    logic        row_irq [MAX_ROWS];
    logic        row_trig [MAX_ROWS];
    int          row_rearm [MAX_ROWS];  // Cycles after cont before setting panel halt
    int          row_eae [MAX_ROWS];    // EAE1 length, -1 uses a random SC
    int          row_first [MAX_ROWS];
    int          row_len [MAX_ROWS];
    logic [4:0]  path_mem [256];
    int          n_rows = 0;
    int          n_states = 0;
    int          cycles = 0;
    logic [31:0] lfsr = 32'hb73f_088f;

    pdp8_cpu_ctl i_pdp8_cpu_ctl (
        .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
        .int_req, .prdata, .pready, .state, .int_in_prog
    );

    ctl_checker i_ctl_checker (.clk, .reset, .state, .int_in_prog, .pready, .done);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (n_rows > 0 && cycles > n_rows * 64) begin
            $display("Timeout: the machine did not finish its rows within %0d cycles",
                     n_rows * 64);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        repeat (n) begin
            lfsr  = lfsr_step(lfsr);
            value = (value << 1) | lfsr[0];
        end
    endtask

    task automatic add_row(input logic [11:0] ctrl, instr, input logic irq, trig,
                           input int rearm, eae);
        row_ctrl[n_rows]  = ctrl;
        row_instr[n_rows] = instr;
        row_irq[n_rows]   = irq;
        row_trig[n_rows]  = trig;
        row_rearm[n_rows] = rearm;
        row_eae[n_rows]   = eae;
        row_first[n_rows] = n_states;
        row_len[n_rows]   = 0;
        n_rows++;
    endtask

    task automatic push(input logic [4:0] s0, s1 = NONE, s2 = NONE, s3 = NONE,
                        s4 = NONE, s5 = NONE);
        logic [4:0] s [6];
        s = '{s0, s1, s2, s3, s4, s5};
        foreach (s[i]) begin
            if (s[i] != NONE) begin
                path_mem[n_states] = s[i];
                n_states++;
                row_len[n_rows-1]++;
            end
        end
    endtask

    // Each row lists the state changes after leaving the halted F0
    task automatic build_table();
        add_row(12'h001, 12'o1020, 0, 0, 0, 0);     // Direct TAD
        push(FW, F1, F2, F3, E0, EW);
        push(E1, E2, E3, F0);
        add_row(12'h001, 12'o1420, 0, 0, 0, 0);     // Indirect TAD
        push(FW, F1, F2, F3, D0, DW);
        push(D3, E0, EW, E1, E2, E3);
        push(F0);
        add_row(12'h009, 12'o1420, 0, 0, 0, 0);     // Auto-index
        push(FW, F1, F2, F3, D0, DW);
        push(D1, D2, D3, E0, EW, E1);
        push(E2, E3, F0);
        add_row(12'h001, 12'o5420, 0, 0, 0, 0);     // Indirect JMP
        push(FW, F1, F2, F3, D0, DW);
        push(D3, F0);
        add_row(12'h000, HLT, 0, 0, 0, 0);
        push(FW, F1, F2, F3, F0);
        add_row(12'h004, HLT, 0, 0, 4, 0);          // User mode, runs HLT twice
        push(FW, F1, F2, F3, F0);
        push(FW, F1, F2, F3, F0);
        add_row(12'h001, 12'o1020, 0, 1, 0, 0);     // Panel trigger
        push(HW, H1, H2, H3, F0);
        add_row(12'h003, 12'o1420, 0, 0, 0, 0);     // Single step
        push(FW, F1, F2, F3, D0, DW);
        push(D3, E0, EW, E1, E2, E3);
        push(F0);
        add_row(12'h001, MUY, 0, 0, 0, `PDP8_MULDIV_STEPS + 1);
        push(FW, F1, F2A, F3, E0, EW);
        push(E1, EAE0, EAE1, F3, F0);
        add_row(12'h001, 12'o7411, 0, 0, 0, -1);
        push(FW, F1, F2A, EAE0, EAE1, F3);
        push(F0);
        add_row(12'h011, MUY, 0, 0, 0, `PDP8_MULDIV_STEPS + 1);   // Mode B
        push(FW, F1, F2B, D0, DW, D3);
        push(E0, EW, E1, EAE0, EAE1, F3);
        push(F0);
        add_row(12'h000, ION, 1, 0, 4, 0);          // ION holds off the pending request
        push(FW, F1, F2, F3, F0);
        push(FW, F1, F2, F3, F0);
        add_row(12'h000, 12'o1020, 1, 0, 9, 0);     // Interrupt after one instruction
        push(FW, F1, F2, F3, E0, EW);
        push(E1, E2, E3, F0, E0, EW);
        push(E1, E2, E3, F0);
        add_row(12'h001, ION, 0, 0, 0, 0);
        push(FW, F1, F2, F3, F0);
        add_row(12'h001, IOF, 0, 0, 0, 0);
        push(FW, F1, F2, F3, F0);
        add_row(12'h000, 12'o1020, 1, 0, 9, 0);     // No interrupt, TAD runs twice
        push(FW, F1, F2, F3, E0, EW);
        push(E1, E2, E3, F0, FW, F1);
        push(F2, F3, E0, EW, E1, E2);
        push(E3, F0);
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [11:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [11:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        data    = prdata;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_for_state(input major_state_t s);
        while (state != s)
            @(negedge clk);
    endtask

    initial begin
        int           sc;
        int           eae;
        int           idle;
        logic [11:0]  status;
        major_state_t holds [2];
        holds   = '{D0, E0};                        // Single-step stops
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        int_req = 1'b0;
        reset   = 1'b1;
        build_table();
        repeat (2) @(negedge clk);
        reset = 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            sc  = 0;
            eae = row_eae[r];
            if (eae < 0) begin
                draw_bits(5, sc);
                eae = sc + 1;                       // EAE1 runs SC+1 cycles
            end
            apb_write(ADDR_INSTR, row_instr[r]);
            apb_write(ADDR_CTRL, row_ctrl[r]);
            apb_write(ADDR_SC, 12'(sc));
            int_req = row_irq[r];
            i_ctl_checker.start_row(eae);
            for (int j = 0; j < row_len[r]; j++)
                i_ctl_checker.expect_state(path_mem[row_first[r] + j]);
            apb_write(ADDR_CMD, row_trig[r] ? 12'h002 : 12'h001);
            if (row_rearm[r] > 0) begin
                repeat (row_rearm[r]) @(negedge clk);
                apb_write(ADDR_CTRL, row_ctrl[r] | 12'h001);
            end
            if (row_ctrl[r][CTRL_SSTEP]) begin
                foreach (holds[h]) begin
                    wait_for_state(holds[h]);
                    apb_read(ADDR_STATUS, status);
                    // int_ena and int_in_prog still clear here
                    i_ctl_checker.compare_value("prdata", 12'(holds[h]), status);
                    apb_write(ADDR_CMD, 12'h001);
                end
            end
            while (!done)
                @(negedge clk);
            draw_bits(4, idle);
            repeat (idle) @(negedge clk);
        end
        $display("Checked %0d rows, %0d errors", n_rows, i_ctl_checker.errors);
        if (i_ctl_checker.errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/ctl_checker.sv
`default_nettype none

module ctl_checker
    import pdp8_cycle_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         reset,
    input  wire major_state_t state,
    input  wire logic         int_in_prog,
    input  wire logic         pready,
    output logic              done
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [4:0]   exp_q [$];    // Expected state changes for the current row
    int           exp_len = 0;
    int           idx = 0;
    int           eae_exp = 0;  // Expected EAE1 length, 0 skips the check
    int           eae_run = 0;
    int           errors = 0;
    logic         armed = 1'b0;
    logic         ip_exp = 1'b0;
    logic [4:0]   exp_prev = F0; // Last expected state reached in this row
    major_state_t prev = F0;

    assign done = armed && exp_len > 0 && idx == exp_len;

    task automatic start_row(input int eae_cycles);
        exp_q.delete();
        exp_len  = 0;
        idx      = 0;
        eae_exp  = eae_cycles;
        exp_prev = F0;
        armed    = 1'b1;
    endtask

    task automatic expect_state(input logic [4:0] s);
        exp_q.push_back(s);
        exp_len++;
    endtask

    task automatic compare_value(input string name, input logic [11:0] expected, observed);
        if (observed !== expected) begin
            errors++;
            $display("Fail %s: expected 0x%h, observed 0x%h at %0t",
                     name, expected, observed, $time);
        end
    endtask

    // Outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (reset) begin
            prev    = F0;
            ip_exp  = 1'b0;
            eae_run = 0;
        end else begin
            if (state != prev) begin
                if (idx < exp_len) begin
                    compare_value("state", 12'(exp_q[idx]), 12'(state));
                    if (exp_prev == F0 && exp_q[idx] == E0)
                        ip_exp = 1'b1;              // Interrupt taken
                    else if (exp_prev == F0 && exp_q[idx] == FW)
                        ip_exp = 1'b0;
                    exp_prev = exp_q[idx];
                    idx++;
                end else begin
                    errors++;
                    $display("State moved to 0x%h although the expected path had ended", state);
                end
            end
            compare_value("int_in_prog", 12'(ip_exp), 12'(int_in_prog));
            compare_value("pready", 12'h001, 12'(pready));   // No wait states
            if (state == EAE1)
                eae_run = (prev == EAE1) ? eae_run + 1 : 1;
            else if (prev == EAE1 && eae_exp != 0)
                compare_value("EAE1 cycles", 12'(eae_exp), 12'(eae_run));
            prev = state;
        end
    end

endmodule

`default_nettype wire

//--- src/pdp8_cpu_ctl.sv
`default_nettype none
`include "pdp8_config.svh"

module pdp8_cpu_ctl
    import pdp8_isa_pkg::*;
    import pdp8_cycle_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       psel,
    input  wire logic                       penable,
    input  wire logic                       pwrite,
    input  wire logic [3:0]                 paddr,
    input  wire logic [`PDP8_WORD_BITS-1:0] pwdata,
    input  wire logic                       int_req,
    output logic      [`PDP8_WORD_BITS-1:0] prdata,
    output logic                            pready,
    output major_state_t                    state,
    output logic                            int_in_prog
);

    logic        halt;
    logic        single_step;
    logic        uf;
    logic        index;
    logic        eae_mode;
    logic        cont;
    logic        trigger;
    logic        int_ena;
    logic        int_inh;
    logic        eae_loop;
    logic [4:0]  sc_value;
    instr_word_t instruction;

    front_panel_apb i_front_panel_apb (
        .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
        .state, .int_in_prog, .int_ena, .prdata, .pready,
        .halt, .single_step, .uf, .index, .eae_mode,
        .instruction, .sc_value, .cont, .trigger
    );

    interrupt_ctrl i_interrupt_ctrl (
        .clk, .reset, .state, .instruction, .int_req, .int_ena, .int_inh
    );

    eae_step_counter i_eae_step_counter (
        .clk, .reset, .state, .instruction, .sc_value, .eae_loop
    );

    major_state_seq i_major_state_seq (
        .clk, .reset, .halt, .single_step, .cont, .trigger, .int_req,
        .int_ena, .int_inh, .uf, .instruction, .eae_mode, .eae_loop,
        .index, .state, .int_in_prog
    );

endmodule

`default_nettype wire

//--- src/major_state_seq.sv
`default_nettype none
`include "pdp8_config.svh"

module major_state_seq
    import pdp8_isa_pkg::*;
    import pdp8_cycle_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        halt,
    input  wire logic        single_step,
    input  wire logic        cont,
    input  wire logic        trigger,
    input  wire logic        int_req,
    input  wire logic        int_ena,
    input  wire logic        int_inh,
    input  wire logic        uf,
    input  wire instr_word_t instruction,
    input  wire logic        eae_mode,
    input  wire logic        eae_loop,
    input  wire logic        index,
    output major_state_t     state,
    output logic             int_in_prog
);

    localparam bit HAS_EAE = (`PDP8_HAS_EAE != 0);

    logic       halt_ff;
    logic       eae_done;     // EAE1 finished, F3 completes the instruction
    logic       int_take;
    logic       is_opr3;
    logic       is_hlt;
    logic       eae_op;
    logic       muldiv;
    logic       f2a_eae;
    logic       f2b_eae;
    logic       f2b_defer;
    logic [3:0] low;
    logic [4:0] eae_key;

    assign low     = instruction.opr.micro[3:0];
    assign eae_key = {instruction.opr.micro[5], low};

    // Group 3 operate words carry bit 0 set
    assign is_opr3 = instruction.opr.opcode == OP_OPR && instruction.opr.group
                     && instruction.opr.micro[0];
    assign is_hlt  = instruction.opr.opcode == OP_OPR && instruction.opr.group
                     && instruction.opr.micro[1:0] == 2'b10;

    // NOP and SWBA take the plain fetch path
    assign eae_op  = HAS_EAE && is_opr3 && eae_key != 5'b00001 && eae_key != 5'b10111;
    assign muldiv  = HAS_EAE && (instruction == MUY || instruction == DIV);

    // IOF in the panel register blocks the interrupt for the ION/IOF pair
    assign int_take = int_req && int_ena && !int_inh && instruction != IOF;

    always_comb begin
        f2a_eae   = low inside {4'b1001, 4'b1011, 4'b1101, 4'b1111};
        f2b_eae   = (!instruction.opr.micro[5] && low inside {4'b1011, 4'b1101, 4'b1111})
                    || instruction.opr.micro == 8'b0000_1001;     // NMI
        f2b_defer = (!instruction.opr.micro[5] && low inside {4'b0101, 4'b0111})
                    || (instruction.opr.micro[5] && low inside {4'b0011, 4'b0101});
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= F0;
            halt_ff     <= 1'b1;
            int_in_prog <= 1'b0;
            eae_done    <= 1'b0;
        end else begin
            case (state)
                F0: begin
                    eae_done <= 1'b0;
                    if (cont) begin
                        state       <= FW;
                        int_in_prog <= 1'b0;
                    end else if (halt_ff) begin
                        if (trigger)
                            state <= HW;
                    end else if (int_take) begin
                        state       <= E0;          // Interrupt uses the JMS to 0 execute path
                        int_in_prog <= 1'b1;
                    end else begin
                        state       <= FW;
                        int_in_prog <= 1'b0;
                    end
                end
                FW: state <= F1;
                F1: begin
                    halt_ff <= 1'b0;
                    if (eae_op)
                        state <= eae_mode ? F2B : F2A;
                    else
                        state <= F2;
                end
                F2:  state <= F3;
                F2A: state <= f2a_eae ? EAE0 : F3;   // MUY/DIV fetch the operand via E0
                F2B: begin
                    if (f2b_eae)
                        state <= EAE0;
                    else if (f2b_defer)
                        state <= D0;
                    else
                        state <= F3;
                end
                F3: begin
                    if (is_hlt) begin
                        halt_ff <= !uf || halt;     // HLT traps in user mode
                        state   <= F0;
                    end else if (muldiv && !eae_done) begin
                        state <= E0;
                    end else if (instruction.mem.opcode inside {OP_IOT, OP_OPR}) begin
                        halt_ff <= halt;
                        state   <= F0;
                    end else if (instruction.mem.indirect) begin
                        state <= D0;
                    end else if (instruction.mem.opcode == OP_JMP) begin
                        halt_ff <= halt;
                        state   <= F0;
                    end else begin
                        state <= E0;                // JMS and the data references
                    end
                end
                D0: state <= (!single_step || cont) ? DW : D0;
                DW: state <= index ? D1 : D3;       // Auto-index adds D1, D2
                D1: state <= D2;
                D2: state <= D3;
                D3: begin
                    if (instruction.mem.opcode == OP_JMP) begin
                        halt_ff <= halt;
                        state   <= F0;
                    end else begin
                        state <= E0;
                    end
                end
                E0: state <= (!single_step || cont) ? EW : E0;
                EW: state <= E1;
                E1: state <= muldiv ? EAE0 : E2;
                E2: state <= E3;
                E3: begin
                    halt_ff <= halt;
                    state   <= F0;
                end
                EAE0: state <= EAE1;
                EAE1: begin
                    if (!eae_loop) begin
                        state    <= F3;
                        eae_done <= 1'b1;
                    end
                end
                HW: state <= H1;
                H1: state <= H2;
                H2: state <= H3;
                H3: state <= F0;
                default: state <= F0;
            endcase
        end
    end

    a_state_legal: assert property (
        @(posedge clk) disable iff (reset)
        $unsigned(state) <= $unsigned(H3)
    );

    a_int_flag_at_f0: assert property (
        @(posedge clk) disable iff (reset)
        (int_in_prog != $past(int_in_prog)) |-> ($past(state) == F0 && state != F0)
    );

endmodule

`default_nettype wire

//--- src/eae_step_counter.sv
`default_nettype none
`include "pdp8_config.svh"

module eae_step_counter
    import pdp8_isa_pkg::*;
    import pdp8_cycle_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         reset,
    input  wire major_state_t state,
    input  wire instr_word_t  instruction,
    input  wire logic [4:0]   sc_value,
    output logic              eae_loop
);

    logic [4:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (state == EAE0) begin
            if (instruction == MUY || instruction == DIV)
                count <= 5'(`PDP8_MULDIV_STEPS);   // Fixed length for multiply/divide
            else
                count <= sc_value;                 // Shifts use the panel step count
        end else if (state == EAE1 && count != 5'd0) begin
            count <= count - 5'd1;
        end
    end

    // Stay in EAE1 while steps remain, so EAE1 lasts count+1 cycles
    assign eae_loop = (count != 5'd0);

    a_count_only_in_eae1: assert property (
        @(posedge clk) disable iff (reset)
        (state != EAE1) |=> (count >= $past(count))
    );

endmodule

`default_nettype wire

//--- src/interrupt_ctrl.sv
`default_nettype none

module interrupt_ctrl
    import pdp8_isa_pkg::*;
    import pdp8_cycle_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         reset,
    input  wire major_state_t state,
    input  wire instr_word_t  instruction,
    input  wire logic         int_req,
    output logic              int_ena,
    output logic              int_inh
);

    logic f0_req;   // Request seen while in F0

    // IOT decode happens in F3, where the sequencer finishes with the word
    always_ff @(posedge clk) begin
        if (reset) begin
            int_ena <= 1'b0;
            int_inh <= 1'b0;
            f0_req  <= 1'b0;
        end else begin
            f0_req <= (state == F0) && int_req;

            if (state == F3) begin
                if (instruction == ION) begin
                    int_ena <= 1'b1;
                    int_inh <= 1'b1;               // Hold off for one instruction
                end else begin
                    int_inh <= 1'b0;
                    if (instruction == IOF)
                        int_ena <= 1'b0;
                end
            end else if (state == E0 && f0_req) begin
                // F0 only goes to E0 when the interrupt is taken
                int_ena <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/front_panel_apb.sv
`default_nettype none
`include "pdp8_config.svh"

module front_panel_apb
    import pdp8_isa_pkg::*;
    import pdp8_cycle_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       psel,
    input  wire logic                       penable,
    input  wire logic                       pwrite,
    input  wire logic [3:0]                 paddr,
    input  wire logic [`PDP8_WORD_BITS-1:0] pwdata,
    input  wire major_state_t               state,
    input  wire logic                       int_in_prog,
    input  wire logic                       int_ena,
    output logic      [`PDP8_WORD_BITS-1:0] prdata,
    output logic                            pready,
    output logic                            halt,
    output logic                            single_step,
    output logic                            uf,
    output logic                            index,
    output logic                            eae_mode,
    output instr_word_t                     instruction,
    output logic      [4:0]                 sc_value,
    output logic                            cont,
    output logic                            trigger
);

    localparam int W = `PDP8_WORD_BITS;

    logic             wr_access;
    logic             rd_setup;
    logic [W-1:0]     rd_mux;

    assign pready    = 1'b1;                        // No wait states
    assign wr_access = psel && penable && pwrite;
    assign rd_setup  = psel && !penable && !pwrite; // Sample read data one cycle early

    always_comb begin
        case (paddr)
            ADDR_STATUS: rd_mux = W'({int_ena, int_in_prog, state});
            ADDR_INSTR:  rd_mux = instruction;
            ADDR_SC:     rd_mux = W'(sc_value);
            default:     rd_mux = '0;              // CMD reads as zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            halt        <= 1'b0;
            single_step <= 1'b0;
            uf          <= 1'b0;
            index       <= 1'b0;
            eae_mode    <= 1'b0;
            instruction <= '0;
            sc_value    <= '0;
            cont        <= 1'b0;
            trigger     <= 1'b0;
            prdata      <= '0;
        end else begin
            // Pulses last one cycle only
            cont    <= wr_access && paddr == ADDR_CMD && pwdata[CMD_CONT];
            trigger <= wr_access && paddr == ADDR_CMD && pwdata[CMD_TRIGGER];

            if (wr_access) begin
                case (paddr)
                    ADDR_CTRL: begin
                        halt        <= pwdata[CTRL_HALT];
                        single_step <= pwdata[CTRL_SSTEP];
                        uf          <= pwdata[CTRL_UF];
                        index       <= pwdata[CTRL_INDEX];
                        eae_mode    <= pwdata[CTRL_EAE_B];
                    end
                    ADDR_INSTR: instruction <= pwdata;
                    ADDR_SC:    sc_value    <= pwdata[4:0];
                    default:    ;
                endcase
            end

            if (rd_setup)
                prdata <= rd_mux;
        end
    end

    // A CMD write needs setup plus access, so pulses can never run together
    a_cmd_pulse_single: assert property (
        @(posedge clk) disable iff (reset)
        (cont || trigger) |=> !(cont || trigger)
    );

endmodule

`default_nettype wire

//--- src/pdp8_cycle_pkg.sv
`default_nettype none

package pdp8_cycle_pkg;

    // F0 must stay at zero, the reset state
    typedef enum logic [4:0] {
        F0, FW, F1, F2, F2A, F2B, F3,       // Fetch
        D0, DW, D1, D2, D3,                 // Defer
        E0, EW, E1, E2, E3,                 // Execute
        EAE0, EAE1,                         // Extended arithmetic
        HW, H1, H2, H3                      // Panel cycle
    } major_state_t;

    // Front panel register map, byte addresses
    localparam logic [3:0] ADDR_CTRL   = 4'h0;
    localparam logic [3:0] ADDR_CMD    = 4'h4;   // Write only
    localparam logic [3:0] ADDR_INSTR  = 4'h8;
    localparam logic [3:0] ADDR_SC     = 4'hC;
    localparam logic [3:0] ADDR_STATUS = 4'h0;   // Read side of CTRL

    // CTRL bit positions
    localparam int CTRL_HALT   = 0;
    localparam int CTRL_SSTEP  = 1;
    localparam int CTRL_UF     = 2;
    localparam int CTRL_INDEX  = 3;
    localparam int CTRL_EAE_B  = 4;

    // CMD bit positions
    localparam int CMD_CONT    = 0;
    localparam int CMD_TRIGGER = 1;

endpackage

`default_nettype wire

//--- src/pdp8_isa_pkg.sv
`default_nettype none

package pdp8_isa_pkg;

    typedef enum logic [2:0] {
        OP_AND = 3'd0,
        OP_TAD = 3'd1,
        OP_ISZ = 3'd2,
        OP_DCA = 3'd3,
        OP_JMS = 3'd4,
        OP_JMP = 3'd5,
        OP_IOT = 3'd6,
        OP_OPR = 3'd7
    } opcode_t;

    // Memory reference layout, opcodes 0 to 5
    typedef struct packed {
        opcode_t    opcode;
        logic       indirect;
        logic       cur_page;   // Page bit, current page vs page zero
        logic [6:0] offset;
    } mem_ref_t;

    // Operate layout, group bit picks group 1 or groups 2/3
    typedef struct packed {
        opcode_t    opcode;
        logic       group;
        logic [7:0] micro;
    } operate_t;

    typedef union packed {
        mem_ref_t mem;
        operate_t opr;
    } instr_word_t;

    // Instructions the control section recognises by full word
    localparam logic [11:0] ION = 12'o6001;
    localparam logic [11:0] IOF = 12'o6002;
    localparam logic [11:0] HLT = 12'o7402;
    localparam logic [11:0] MUY = 12'o7405;
    localparam logic [11:0] DIV = 12'o7407;

endpackage

`default_nettype wire

//--- src/pdp8_config.svh
`ifndef PDP8_CONFIG_SVH
`define PDP8_CONFIG_SVH

// Instruction and panel register width
`define PDP8_WORD_BITS 12

// 1 builds the EAE paths (F2A/F2B, EAE0/EAE1), 0 leaves E1 going straight to E2
`define PDP8_HAS_EAE 1

// EAE1 passes for MUY and DIV
`define PDP8_MULDIV_STEPS 12

`endif
